// ==== source/rx_pkg.sv ====
`default_nettype none

package rx_pkg;

    // version register contents
    localparam logic [7:0] RX_VERSION = 8'd2;

    // K28.5 comma, bit 9 is 'a' and goes on the wire first
    localparam logic [9:0] K28_5_RDN = 10'b0011111010;  // start at rd-
    localparam logic [9:0] K28_5_RDP = 10'b1100000101;  // start at rd+

    typedef enum logic {
        align_hunt,
        align_locked
    } align_state_e;

    // register map of the wishbone slave
    typedef enum logic [3:0] {
        addr_version  = 4'd0,   // read version, write soft reset
        addr_rx_reset = 4'd1,   // write only
        addr_config   = 4'd2,
        addr_level_lo = 4'd3,
        addr_level_hi = 4'd4,
        addr_dec_err  = 4'd5,
        addr_lost_err = 4'd6
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== source/rx_symbol_align.sv ====
`default_nettype none

module rx_symbol_align (
    input  wire        BUS_CLK,
    input  wire        RST,
    input  wire        rx_data,
    input  wire        invert_rx,
    output logic [9:0] sym,
    output logic       sym_valid,
    output logic       locked
);
    import rx_pkg::*;

    align_state_e state;
    logic         rx_bit;       // sampled line, polarity fixed
    logic [9:0]   window;
    logic [9:0]   window_next;
    logic [3:0]   bit_cnt;      // bits of the current symbol taken so far

    assign window_next = {window[8:0], rx_bit};
    assign locked      = (state == align_locked);

    // one bit per clock
    always_ff @(posedge BUS_CLK) begin
        rx_bit <= rx_data ^ invert_rx;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            state     <= align_hunt;
            window    <= '0;
            bit_cnt   <= '0;
            sym_valid <= 1'b0;
        end else begin
            window    <= window_next;
            sym_valid <= 1'b0;
            case (state)
                align_hunt: begin
                    // either comma polarity is accepted
                    if (window == K28_5_RDN || window == K28_5_RDP) begin
                        state   <= align_locked;
                        bit_cnt <= 4'd1;    // first bit of next symbol enters now
                    end
                end
                align_locked: begin
                    if (bit_cnt == 4'd9) begin
                        bit_cnt   <= '0;
                        sym_valid <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                default: begin
                    state <= align_hunt;
                end
            endcase
        end
    end

    // symbol boundary reached on counter wrap
    always_ff @(posedge BUS_CLK) begin
        if (state == align_locked && bit_cnt == 4'd9)
            sym <= window_next;
    end

endmodule

`default_nettype wire

// ==== source/rx_8b10b_decode.sv ====
`default_nettype none

module rx_8b10b_decode (
    input  wire        BUS_CLK,
    input  wire        RST,
    input  wire  [9:0] sym,
    input  wire        sym_valid,
    output logic [7:0] byte_data,
    output logic       byte_k,
    output logic       byte_valid,
    output logic [7:0] decoder_err_cnt
);
    import rx_pkg::*;

    logic [5:0] abcdei;
    logic [3:0] fghj;
    logic [3:0] fghj_dec;   // k28 after a 110000 prefix uses the inverted 4b set
    logic [4:0] d5;
    logic [2:0] d3;
    logic       v6;
    logic       v4;
    logic       is_k28;
    logic [2:0] ones6;
    logic [2:0] ones4;
    logic       rd;         // running disparity, 1 is positive
    logic       rd_mid;
    logic       rd_next;
    logic       err6;
    logic       err4;
    logic       sym_bad;

    assign abcdei   = sym[9:4];
    assign fghj     = sym[3:0];
    assign is_k28   = (abcdei == 6'b001111) || (abcdei == 6'b110000);
    assign fghj_dec = (is_k28 && abcdei[5]) ? ~fghj : fghj;
    assign ones6    = 3'($countones(abcdei));
    assign ones4    = 3'($countones(fghj));
    assign sym_bad  = !v6 || !v4 || err6 || err4;

    // 6b sub-block, both disparity forms per entry
    always_comb begin
        v6 = 1'b1;
        case (abcdei)
            6'b100111, 6'b011000: d5 = 5'd0;
            6'b011101, 6'b100010: d5 = 5'd1;
            6'b101101, 6'b010010: d5 = 5'd2;
            6'b110001:            d5 = 5'd3;
            6'b110101, 6'b001010: d5 = 5'd4;
            6'b101001:            d5 = 5'd5;
            6'b011001:            d5 = 5'd6;
            6'b111000, 6'b000111: d5 = 5'd7;
            6'b111001, 6'b000110: d5 = 5'd8;
            6'b100101:            d5 = 5'd9;
            6'b010101:            d5 = 5'd10;
            6'b110100:            d5 = 5'd11;
            6'b001101:            d5 = 5'd12;
            6'b101100:            d5 = 5'd13;
            6'b011100:            d5 = 5'd14;
            6'b010111, 6'b101000: d5 = 5'd15;
            6'b011011, 6'b100100: d5 = 5'd16;
            6'b100011:            d5 = 5'd17;
            6'b010011:            d5 = 5'd18;
            6'b110010:            d5 = 5'd19;
            6'b001011:            d5 = 5'd20;
            6'b101010:            d5 = 5'd21;
            6'b011010:            d5 = 5'd22;
            6'b111010, 6'b000101: d5 = 5'd23;
            6'b110011, 6'b001100: d5 = 5'd24;
            6'b100110:            d5 = 5'd25;
            6'b010110:            d5 = 5'd26;
            6'b110110, 6'b001001: d5 = 5'd27;
            6'b001110, 6'b001111, 6'b110000: d5 = 5'd28;   // D.28 and K.28
            6'b101110, 6'b010001: d5 = 5'd29;
            6'b011110, 6'b100001: d5 = 5'd30;
            6'b101011, 6'b010100: d5 = 5'd31;
            default: begin
                d5 = 5'd0;
                v6 = 1'b0;
            end
        endcase
    end

    // 4b sub-block
    always_comb begin
        v4 = 1'b1;
        case (fghj_dec)
            4'b0100, 4'b1011: d3 = 3'd0;
            4'b1001:          d3 = 3'd1;
            4'b0101:          d3 = 3'd2;
            4'b0011, 4'b1100: d3 = 3'd3;
            4'b0010, 4'b1101: d3 = 3'd4;
            4'b1010:          d3 = 3'd5;
            4'b0110:          d3 = 3'd6;
            4'b0001, 4'b1110, 4'b1000, 4'b0111: d3 = 3'd7;
            default: begin
                d3 = 3'd0;
                v4 = 1'b0;
            end
        endcase
    end

    // disparity check, 6b first then 4b
    always_comb begin
        rd_mid = rd;
        err6   = 1'b0;
        if (ones6 == 3'd4) begin
            err6   = rd;        // +2 block only allowed from rd-
            rd_mid = 1'b1;
        end else if (ones6 == 3'd2) begin
            err6   = !rd;
            rd_mid = 1'b0;
        end else if (abcdei == 6'b111000 || abcdei == 6'b000111) begin
            err6 = (abcdei[5] == rd);   // neutral but rd dependent
        end
        rd_next = rd_mid;
        err4    = 1'b0;
        if (ones4 == 3'd3) begin
            err4    = rd_mid;
            rd_next = 1'b1;
        end else if (ones4 == 3'd1) begin
            err4    = !rd_mid;
            rd_next = 1'b0;
        end else if (fghj == 4'b1100 || fghj == 4'b0011) begin
            err4 = (fghj[3] == rd_mid);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rd              <= 1'b0;
            byte_valid      <= 1'b0;
            decoder_err_cnt <= '0;
        end else begin
            byte_valid <= 1'b0;
            if (sym_valid) begin
                if (sym == K28_5_RDN || sym == K28_5_RDP) begin
                    rd         <= (sym == K28_5_RDN);  // comma resyncs disparity
                    byte_valid <= 1'b1;
                end else if (sym_bad) begin
                    if (decoder_err_cnt != 8'hFF)
                        decoder_err_cnt <= decoder_err_cnt + 8'd1;
                end else begin
                    rd         <= rd_next;
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (sym_valid) begin
            byte_data <= {d3, d5};
            byte_k    <= is_k28;
        end
    end

endmodule

`default_nettype wire

// ==== source/rx_record_fifo.sv ====
`default_nettype none

module rx_record_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire         BUS_CLK,
    input  wire         RST,
    input  wire  [7:0]  byte_data,
    input  wire         byte_k,
    input  wire         byte_valid,
    input  wire         fifo_read,
    output logic [23:0] rec_data,
    output logic        fifo_empty,
    output logic [15:0] fifo_level,
    output logic [7:0]  lost_err_cnt
);
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [23:0] mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;        // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic [AW:0] level;
    logic [1:0]  byte_idx;
    logic [15:0] rec_hi;        // first two bytes, msb first
    logic        rec_done;
    logic        full;
    logic        push;
    logic        pop;

    assign rec_done = byte_valid && !byte_k && (byte_idx == 2'd2);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push     = rec_done && !full;
    assign pop      = fifo_read && !fifo_empty;  // empty reads are ignored
    assign level    = wr_ptr - rd_ptr;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_level = 16'(level);
    assign rec_data   = mem[rd_ptr[AW-1:0]];     // fall-through output

    // byte position inside the record
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            byte_idx <= 2'd0;
        end else if (byte_valid) begin
            if (byte_k || byte_idx == 2'd2)
                byte_idx <= 2'd0;   // K byte drops a partial record
            else
                byte_idx <= byte_idx + 2'd1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (byte_valid && !byte_k) begin
            if (byte_idx == 2'd0)
                rec_hi[15:8] <= byte_data;
            else if (byte_idx == 2'd1)
                rec_hi[7:0] <= byte_data;
        end
        if (push)
            mem[wr_ptr[AW-1:0]] <= {rec_hi, byte_data};
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            lost_err_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // record dropped, stream cannot be held off
            if (rec_done && full && lost_err_cnt != 8'hFF)
                lost_err_cnt <= lost_err_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/rx_wb_regs.sv ====
`default_nettype none

module rx_wb_regs (
    input  wire         BUS_CLK,
    input  wire         RST,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [3:0]  wb_adr,
    input  wire  [7:0]  wb_dat_w,
    input  wire         locked,
    input  wire  [15:0] fifo_level,
    input  wire  [7:0]  decoder_err_cnt,
    input  wire  [7:0]  lost_err_cnt,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    output logic        core_rst,
    output logic        rx_rst,
    output logic        invert_rx
);
    import rx_pkg::*;

    reg_addr_e  addr;
    logic       access;     // first cycle with cyc and stb
    logic       wr;
    logic       soft_rst;
    logic [7:0] cfg_reg;
    logic [7:0] rd_mux;

    assign addr   = reg_addr_e'(wb_adr);
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr     = access && wb_we;

    assign core_rst  = RST || soft_rst;
    assign invert_rx = cfg_reg[1];

    // ack and reset pulses share the ack cycle
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wb_ack   <= 1'b0;
            soft_rst <= 1'b0;
            rx_rst   <= 1'b0;
        end else begin
            wb_ack   <= access;
            soft_rst <= wr && (addr == addr_version);
            rx_rst   <= wr && (addr == addr_rx_reset);
        end
    end

    // config survives a receiver reset
    always_ff @(posedge BUS_CLK) begin
        if (core_rst)
            cfg_reg <= 8'h00;
        else if (wr && addr == addr_config)
            cfg_reg <= wb_dat_w;
    end

    always_comb begin
        case (addr)
            addr_version:  rd_mux = RX_VERSION;
            addr_config:   rd_mux = {cfg_reg[7:1], locked};   // bit 0 is rx_ready
            addr_level_lo: rd_mux = fifo_level[7:0];
            addr_level_hi: rd_mux = fifo_level[15:8];
            addr_dec_err:  rd_mux = decoder_err_cnt;
            addr_lost_err: rd_mux = lost_err_cnt;
            default:       rd_mux = 8'h00;
        endcase
    end

    // held through the ack cycle
    always_ff @(posedge BUS_CLK) begin
        if (access)
            wb_dat_r <= rd_mux;
    end

endmodule

`default_nettype wire

// ==== source/rx_core_top.sv ====
`default_nettype none

module rx_core_top #(
    parameter int         FIFO_DEPTH      = 16,
    parameter logic [7:0] DATA_IDENTIFIER = 8'h5A
) (
    input  wire         BUS_CLK,
    input  wire         RST,
    input  wire         rx_data,
    output logic        rx_ready,
    output logic        rx_decoder_err,
    output logic        rx_overflow_err,
    input  wire         fifo_read,
    output logic        fifo_empty,
    output logic [31:0] fifo_data,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [3:0]  wb_adr,
    input  wire  [7:0]  wb_dat_w,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack
);
    logic        core_rst;
    logic        rx_rst;
    logic        dp_rst;        // data path reset
    logic        invert_rx;
    logic [9:0]  sym;
    logic        sym_valid;
    logic        locked;
    logic [7:0]  byte_data;
    logic        byte_k;
    logic        byte_valid;
    logic [7:0]  decoder_err_cnt;
    logic [23:0] rec_data;
    logic [15:0] fifo_level;
    logic [7:0]  lost_err_cnt;

    assign dp_rst = core_rst || rx_rst;

    rx_symbol_align u_align (
        .BUS_CLK   (BUS_CLK),
        .RST       (dp_rst),
        .rx_data   (rx_data),
        .invert_rx (invert_rx),
        .sym       (sym),
        .sym_valid (sym_valid),
        .locked    (locked)
    );

    rx_8b10b_decode u_decode (
        .BUS_CLK         (BUS_CLK),
        .RST             (dp_rst),
        .sym             (sym),
        .sym_valid       (sym_valid),
        .byte_data       (byte_data),
        .byte_k          (byte_k),
        .byte_valid      (byte_valid),
        .decoder_err_cnt (decoder_err_cnt)
    );

    rx_record_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .BUS_CLK      (BUS_CLK),
        .RST          (dp_rst),
        .byte_data    (byte_data),
        .byte_k       (byte_k),
        .byte_valid   (byte_valid),
        .fifo_read    (fifo_read),
        .rec_data     (rec_data),
        .fifo_empty   (fifo_empty),
        .fifo_level   (fifo_level),
        .lost_err_cnt (lost_err_cnt)
    );

    rx_wb_regs u_regs (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .locked          (locked),
        .fifo_level      (fifo_level),
        .decoder_err_cnt (decoder_err_cnt),
        .lost_err_cnt    (lost_err_cnt),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .core_rst        (core_rst),
        .rx_rst          (rx_rst),
        .invert_rx       (invert_rx)
    );

    // identifier byte on top of each record
    assign fifo_data       = {DATA_IDENTIFIER, rec_data};
    assign rx_ready        = locked;
    assign rx_decoder_err  = (decoder_err_cnt != 8'd0);
    assign rx_overflow_err = (lost_err_cnt != 8'd0);

endmodule

`default_nettype wire

// ==== verif/rx_core_assertions.sv ====
`default_nettype none

module rx_core_assertions #(
    parameter int FIFO_DEPTH = 16
) (
    input wire        BUS_CLK,
    input wire        RST,
    input wire        wb_cyc,
    input wire        wb_stb,
    input wire        wb_ack,
    input wire [15:0] fifo_level
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;     // read by the testbench at the end

    // ack only inside an active cycle
    a_ack_in_cycle: assert property (@(posedge BUS_CLK) disable iff (RST)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack high outside a bus cycle");
        end

    a_ack_single: assert property (@(posedge BUS_CLK) disable iff (RST)
        wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack high for two cycles");
        end

    // full FIFO must refuse further records
    a_level_bound: assert property (@(posedge BUS_CLK) disable iff (RST)
        fifo_level <= 16'(FIFO_DEPTH))
        else begin
            fail_count++;
            $error("fifo_level above the FIFO depth");
        end

endmodule

`default_nettype wire

// ==== verif/tb_rx_core.sv ====
`default_nettype none

module tb_rx_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rx_pkg::*;

    localparam logic [7:0] DATA_ID = 8'h5A;
    localparam int TX_COMMA = 256;     // queue codes above the byte range
    localparam int TX_BAD   = 512;

    logic        BUS_CLK;
    logic        RST;
    logic        rx_data;
    logic        rx_ready;
    logic        rx_decoder_err;
    logic        rx_overflow_err;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;

    int          tx_q[$];           // bytes and codes still to serialize
    logic [31:0] exp_q[$];
    logic [9:0]  tx_sym;
    int          tx_bit = 0;
    logic        tx_rd = 1'b0;
    logic        invert_line = 1'b0;
    logic        drain_en = 1'b0;
    int          mismatches = 0;
    int          timeouts = 0;

    rx_core_top #(
        .FIFO_DEPTH      (4),
        .DATA_IDENTIFIER (DATA_ID)
    ) dut (
        .BUS_CLK(BUS_CLK), .RST(RST), .rx_data(rx_data), .rx_ready(rx_ready),
        .rx_decoder_err(rx_decoder_err), .rx_overflow_err(rx_overflow_err),
        .fifo_read(fifo_read), .fifo_empty(fifo_empty), .fifo_data(fifo_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    bind rx_core_top rx_core_assertions #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) asrt (
        .BUS_CLK(BUS_CLK), .RST(RST), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .wb_ack(wb_ack), .fifo_level(fifo_level)
    );

    always #20 BUS_CLK = ~BUS_CLK;

    // returns {rd after symbol, abcdeifghj}
    // K28.5 is the only control code
    function automatic logic [10:0] enc8b10b(input logic [7:0] d, input logic k,
                                             input logic rd);
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd6;
        if (k)
            return rd ? {1'b0, ~10'b0011111010} : {1'b1, 10'b0011111010};
        case (d[4:0])
            0:  c6 = 6'b100111;
            1:  c6 = 6'b011101;
            2:  c6 = 6'b101101;
            3:  c6 = 6'b110001;
            4:  c6 = 6'b110101;
            5:  c6 = 6'b101001;
            6:  c6 = 6'b011001;
            7:  c6 = 6'b111000;
            8:  c6 = 6'b111001;
            9:  c6 = 6'b100101;
            10: c6 = 6'b010101;
            11: c6 = 6'b110100;
            12: c6 = 6'b001101;
            13: c6 = 6'b101100;
            14: c6 = 6'b011100;
            15: c6 = 6'b010111;
            16: c6 = 6'b011011;
            17: c6 = 6'b100011;
            18: c6 = 6'b010011;
            19: c6 = 6'b110010;
            20: c6 = 6'b001011;
            21: c6 = 6'b101010;
            22: c6 = 6'b011010;
            23: c6 = 6'b111010;
            24: c6 = 6'b110011;
            25: c6 = 6'b100110;
            26: c6 = 6'b010110;
            27: c6 = 6'b110110;
            28: c6 = 6'b001110;
            29: c6 = 6'b101110;
            30: c6 = 6'b011110;
            default: c6 = 6'b101011;
        endcase
        rd6 = ($countones(c6) != 3) ? ~rd : rd;
        if (rd && ($countones(c6) != 3 || c6 == 6'b111000))
            c6 = ~c6;       // rd+ form
        case (d[7:5])
            0: c4 = 4'b1011;
            1: c4 = 4'b1001;
            2: c4 = 4'b0101;
            3: c4 = 4'b1100;
            4: c4 = 4'b1101;
            5: c4 = 4'b1010;
            6: c4 = 4'b0110;
            default: c4 = 4'b1110;
        endcase
        // alternate D.x.7 avoids a run of five
        if (d[7:5] == 3'd7 && ((!rd6 && (d[4:0] == 17 || d[4:0] == 18 || d[4:0] == 20))
                || (rd6 && (d[4:0] == 11 || d[4:0] == 13 || d[4:0] == 14))))
            c4 = 4'b0111;
        if (rd6 && ($countones(c4) != 2 || c4 == 4'b1100))
            c4 = ~c4;
        return {(($countones(c4) != 2) ? ~rd6 : rd6), c6, c4};
    endfunction

    // serializer idles with commas
    always @(negedge BUS_CLK) begin
        logic [10:0] enc;
        int          item;
        if (tx_bit == 0) begin
            if (tx_q.size() > 0)
                item = tx_q.pop_front();
            else
                item = TX_COMMA;
            if (item == TX_BAD) begin
                tx_sym = 10'b1111100000;     // 6b part has no code
            end else begin
                enc    = enc8b10b(item[7:0], item == TX_COMMA, tx_rd);
                tx_sym = enc[9:0];
                tx_rd  = enc[10];
            end
        end
        rx_data = tx_sym[9 - tx_bit] ^ invert_line;
        tx_bit  = (tx_bit == 9) ? 0 : tx_bit + 1;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    // pop lands on the next rising edge
    always @(negedge BUS_CLK) begin
        if (drain_en && !fifo_empty) begin
            if (exp_q.size() == 0) begin
                $display("error: word %h read with nothing expected", fifo_data);
                mismatches++;
            end else begin
                check_value("fifo_data", exp_q.pop_front(), fifo_data);
            end
            fifo_read = 1'b1;
        end else begin
            fifo_read = 1'b0;
        end
    end

    task automatic wb_access(input logic we, input reg_addr_e addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        @(negedge BUS_CLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(negedge BUS_CLK);
            n++;
        end while (!wb_ack && n < 20);
        rdata = wb_dat_r;
        if (wb_ack) begin
            @(negedge BUS_CLK);     // stb held until the edge that takes ack
        end else begin
            $display("error: no ack from register bank at address %0d", addr);
            timeouts++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_e addr, input logic [7:0] data);
        logic [7:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input reg_addr_e addr, output logic [7:0] data);
        wb_access(1'b0, addr, 8'h00, data);
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [7:0] mask,
                             input logic [7:0] exp);
        logic [7:0] d;
        wb_read(addr, d);
        check_value(addr.name(), exp, d & mask);
    endtask

    // poll a register until it shows the value
    task automatic wait_reg(input reg_addr_e addr, input logic [7:0] exp);
        logic [7:0] d;
        int         n;
        n = 0;
        do begin
            wb_read(addr, d);
            n++;
        end while (d !== exp && n < 300);
        if (d !== exp) begin
            $display("error: register %s never reached %h", addr.name(), exp);
            timeouts++;
        end
    endtask

    task automatic wait_ready(input logic level);
        int n;
        n = 0;
        while (rx_ready !== level && n < 2000) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (rx_ready !== level) begin
            $display("error: rx_ready did not go to %b", level);
            timeouts++;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || !fifo_empty) && n < 5000) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("error: %0d expected words never arrived", exp_q.size());
            timeouts++;
        end
    endtask

    // leading comma ends any partial record
    task automatic send_record(input logic [7:0] b0, input logic [7:0] b1,
                               input logic [7:0] b2, input bit expected);
        tx_q.push_back(TX_COMMA);
        tx_q.push_back(b0);
        tx_q.push_back(b1);
        tx_q.push_back(b2);
        if (expected)
            exp_q.push_back({DATA_ID, b0, b1, b2});
    endtask

    task automatic send_random(input bit expected);
        send_record(8'($urandom), 8'($urandom), 8'($urandom), expected);
    endtask

    initial begin
        BUS_CLK   = 1'b0;
        RST       = 1'b1;
        rx_data   = 1'b0;
        fifo_read = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 4'd0;
        wb_dat_w  = 8'h00;
        void'($urandom(34038));
        repeat (16) @(negedge BUS_CLK);
        RST = 1'b0;

        check_value("rx_ready", 1'b0, rx_ready);
        check_value("fifo_empty", 1'b1, fifo_empty);
        check_value("rx_decoder_err", 1'b0, rx_decoder_err);
        check_value("rx_overflow_err", 1'b0, rx_overflow_err);
        check_reg(addr_version, 8'hFF, 8'h02);
        check_reg(addr_dec_err, 8'hFF, 8'h00);
        check_reg(addr_lost_err, 8'hFF, 8'h00);

        // lock then four records held for the level read
        wait_ready(1'b1);
        repeat (4) send_random(1'b1);
        wait_reg(addr_level_lo, 8'(exp_q.size()));
        check_reg(addr_level_hi, 8'hFF, 8'h00);
        drain_en = 1'b1;
        wait_drained();

        // inverted line
        wb_write(addr_config, 8'h82);
        invert_line = 1'b1;
        wb_write(addr_rx_reset, 8'h00);
        wait_ready(1'b1);
        check_reg(addr_config, 8'hFF, 8'h83);
        repeat (2) send_random(1'b1);
        wait_drained();

        // one bad symbol inside the middle record
        send_random(1'b1);
        tx_q.push_back(TX_COMMA);
        tx_q.push_back(8'h11);
        tx_q.push_back(TX_BAD);
        tx_q.push_back(8'h33);
        send_random(1'b1);
        wait_drained();
        check_reg(addr_dec_err, 8'hFF, 8'h01);
        check_value("rx_decoder_err", 1'b1, rx_decoder_err);

        // overflow of a four deep FIFO
        drain_en = 1'b0;
        repeat (4) send_random(1'b1);
        repeat (3) send_random(1'b0);
        wait_reg(addr_lost_err, 8'h03);
        check_reg(addr_level_lo, 8'hFF, 8'h04);
        check_value("rx_overflow_err", 1'b1, rx_overflow_err);
        drain_en = 1'b1;
        wait_drained();

        // receiver reset keeps config
        drain_en = 1'b0;
        repeat (2) send_random(1'b0);
        wait_reg(addr_level_lo, 8'h02);
        wb_write(addr_rx_reset, 8'h00);
        check_reg(addr_level_lo, 8'hFF, 8'h00);
        check_reg(addr_lost_err, 8'hFF, 8'h00);
        check_reg(addr_dec_err, 8'hFF, 8'h00);
        check_value("fifo_empty", 1'b1, fifo_empty);
        check_value("rx_decoder_err", 1'b0, rx_decoder_err);
        check_value("rx_overflow_err", 1'b0, rx_overflow_err);
        check_reg(addr_config, 8'hFE, 8'h82);
        wait_ready(1'b1);

        // soft reset clears config as well
        invert_line = 1'b0;
        wb_write(addr_version, 8'h00);
        wait_ready(1'b0);
        check_reg(addr_config, 8'hFE, 8'h00);
        wait_ready(1'b1);
        drain_en = 1'b1;
        send_random(1'b1);
        wait_drained();

        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, dut.asrt.fail_count);
        if (mismatches == 0 && timeouts == 0 && dut.asrt.fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rx8b10b.f ====
source/rx_pkg.sv
source/rx_symbol_align.sv
source/rx_8b10b_decode.sv
source/rx_record_fifo.sv
source/rx_wb_regs.sv
source/rx_core_top.sv
verif/rx_core_assertions.sv
verif/tb_rx_core.sv
